/* design/scope_pkg.sv */
//////////////////////////////
// scope package
// bus width, register map and edge detector states
//////////////////////////////
package scope_pkg;

  // system bus address width
  localparam int sys_aw_t = 32;

  //////////////////////////////
  // register map
  //////////////////////////////

  // offsets within the low 20 address bits
  typedef enum logic [19:0] {
    REG_CTL = 20'h00000,  // control, bit 0 = clear
    REG_AVG = 20'h00008,  // averaging enable
    REG_DEC = 20'h0000c,  // decimation factor
    REG_SHR = 20'h00010,  // right shift of result
    REG_LVL = 20'h00014,  // trigger level
    REG_HST = 20'h00018   // hysteresis
  } reg_addr_e;

  // schmitt trigger state
  typedef enum logic {
    EDGE_LOW  = 1'b0,  // below band, waiting for rise
    EDGE_HIGH = 1'b1   // above band, waiting for fall
  } edge_state_e;

endpackage: scope_pkg

/* design/scope_regs.sv */
//////////////////////////////
// scope register bank
// system bus slave holding the decimator and
// trigger settings, issues the clear pulse
//////////////////////////////
`timescale 1ns/1ps

module scope_regs #(
  int unsigned DWI = 14,  // level / hysteresis width
  int unsigned DWC = 17,  // decimation counter width
  int unsigned DWS = 4    // shift amount width
)(
  input  logic                            clk,
  input  logic                            rstn,
  // system bus
  input  logic [scope_pkg::sys_aw_t-1:0]  sys_addr,
  input  logic [31:0]                     sys_wdata,
  input  logic                            sys_wen,
  input  logic                            sys_ren,
  output logic [31:0]                     sys_rdata,
  output logic                            sys_ack,
  // control and configuration
  output logic                            ctl_clr,
  output logic                            cfg_avg,
  output logic [DWC-1:0]                  cfg_dec,
  output logic [DWS-1:0]                  cfg_shr,
  output logic signed [DWI-1:0]           cfg_lvl,
  output logic signed [DWI-1:0]           cfg_hst
);

  import scope_pkg::*;

  reg_addr_e reg_sel;  // decoded offset

  assign reg_sel = reg_addr_e'(sys_addr[19:0]);  // upper bits ignored

  //////////////////////////////
  // acknowledge and clear
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sys_ack <= 1'b0;
      ctl_clr <= 1'b0;
    end else begin
      sys_ack <= sys_wen | sys_ren;  // one cycle after request
      ctl_clr <= sys_wen && (reg_sel == REG_CTL) && sys_wdata[0];
    end
  end

  //////////////////////////////
  // write decode
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg_avg <= 1'b0;
      cfg_dec <= '0;
      cfg_shr <= '0;
      cfg_lvl <= '0;
      cfg_hst <= '0;
    end else if (sys_wen) begin
      case (reg_sel)
        REG_AVG: cfg_avg <= sys_wdata[0];
        REG_DEC: cfg_dec <= sys_wdata[DWC-1:0];
        REG_SHR: cfg_shr <= sys_wdata[DWS-1:0];
        REG_LVL: cfg_lvl <= sys_wdata[DWI-1:0];
        REG_HST: cfg_hst <= sys_wdata[DWI-1:0];
        default: ;  // ctl handled above, others ignored
      endcase
    end
  end

  // read mux, each field at its own width
  always_ff @(posedge clk) begin
    if (sys_ren) begin
      case (reg_sel)
        REG_AVG: sys_rdata <= {31'd0, cfg_avg};
        REG_DEC: sys_rdata <= {{(32-DWC){1'b0}}, cfg_dec};
        REG_SHR: sys_rdata <= {{(32-DWS){1'b0}}, cfg_shr};
        REG_LVL: sys_rdata <= {{(32-DWI){cfg_lvl[DWI-1]}}, cfg_lvl};  // sign ext
        REG_HST: sys_rdata <= {{(32-DWI){cfg_hst[DWI-1]}}, cfg_hst};
        default: sys_rdata <= '0;  // ctl and unmapped
      endcase
    end
  end

endmodule: scope_regs

/* design/scope_dec_avg.sv */
//////////////////////////////
// stream decimator
// keeps every Nth sample or sums N samples,
// then arithmetic shift right
//////////////////////////////
`timescale 1ns/1ps

module scope_dec_avg #(
  int unsigned DWI = 14,  // input data width
  int unsigned DWO = 14,  // output data width
  int unsigned DWC = 17,  // decimation counter width
  int unsigned DWS = 4    // shift amount width
)(
  input  logic                  clk,
  input  logic                  rstn,
  // control and configuration
  input  logic                  ctl_clr,
  input  logic                  cfg_avg,
  input  logic [DWC-1:0]        cfg_dec,
  input  logic [DWS-1:0]        cfg_shr,
  // stream input
  input  logic signed [DWI-1:0] sti_dat,
  input  logic                  sti_vld,
  output logic                  sti_rdy,
  // stream output
  output logic signed [DWO-1:0] sto_dat,
  output logic                  sto_vld,
  input  logic                  sto_rdy
);

  localparam int unsigned DWA = DWI + DWC;  // accumulator width

  logic                  run;      // set once out of reset
  logic                  sti_trn;  // input transfer
  logic [DWC-1:0]        dec_n;    // effective factor
  logic [DWC-1:0]        cnt;      // samples in current group
  logic                  last;     // this sample closes the group
  logic signed [DWA-1:0] sti_ext;
  logic signed [DWA-1:0] acc;
  logic signed [DWA-1:0] sum_nxt;
  logic signed [DWA-1:0] res_sel;
  logic signed [DWA-1:0] res_shr;

  //////////////////////////////
  // handshake
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  // space when output empty or leaving now
  assign sti_rdy = run && (!sto_vld || sto_rdy);
  assign sti_trn = sti_vld && sti_rdy;

  //////////////////////////////
  // group counting and sum
  //////////////////////////////

  assign dec_n   = (cfg_dec == '0) ? DWC'(1) : cfg_dec;  // 0 acts as 1
  assign last    = (cnt >= dec_n - DWC'(1));  // also catches factor lowered mid group
  assign sti_ext = {{DWC{sti_dat[DWI-1]}}, sti_dat};
  assign sum_nxt = (cnt == '0) ? sti_ext : acc + sti_ext;  // first sample restarts
  assign res_sel = cfg_avg ? sum_nxt : sti_ext;  // sum or latest sample
  assign res_shr = res_sel >>> cfg_shr;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt <= '0;
    end else if (ctl_clr) begin
      cnt <= '0;  // partial group dropped
    end else if (sti_trn) begin
      cnt <= last ? '0 : cnt + DWC'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (sti_trn) begin
      acc <= sum_nxt;
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sto_vld <= 1'b0;
    end else if (ctl_clr) begin
      sto_vld <= 1'b0;  // pending result discarded
    end else if (sti_trn && last) begin
      sto_vld <= 1'b1;
    end else if (sto_rdy) begin
      sto_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (sti_trn && last) begin
      sto_dat <= res_shr[DWO-1:0];  // truncate to output width
    end
  end

endmodule: scope_dec_avg

/* design/scope_edge.sv */
//////////////////////////////
// schmitt edge detector
// rising and falling trigger pulses
//////////////////////////////
`timescale 1ns/1ps

module scope_edge #(
  int unsigned DWI = 14  // data width
)(
  input  logic                  clk,
  input  logic                  rstn,
  // monitored stream
  input  logic signed [DWI-1:0] sti_dat,
  input  logic                  sti_vld,
  input  logic                  sti_rdy,
  // configuration
  input  logic signed [DWI-1:0] cfg_lvl,
  input  logic signed [DWI-1:0] cfg_hst,
  // triggers
  output logic                  trg_pdg,  // positive edge
  output logic                  trg_ndg   // negative edge
);

  import scope_pkg::*;

  edge_state_e         state;
  logic                sti_trn;
  logic signed [DWI:0] dat_ext;  // one bit wider, no overflow
  logic signed [DWI:0] thr_hi;
  logic signed [DWI:0] thr_lo;

  assign sti_trn = sti_vld && sti_rdy;
  assign dat_ext = {sti_dat[DWI-1], sti_dat};
  assign thr_hi  = {cfg_lvl[DWI-1], cfg_lvl} + {cfg_hst[DWI-1], cfg_hst};
  assign thr_lo  = {cfg_lvl[DWI-1], cfg_lvl} - {cfg_hst[DWI-1], cfg_hst};

  //////////////////////////////
  // state and pulses
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= EDGE_LOW;
      trg_pdg <= 1'b0;
      trg_ndg <= 1'b0;
    end else begin
      trg_pdg <= 1'b0;  // single cycle pulses
      trg_ndg <= 1'b0;
      if (sti_trn) begin
        if ((state == EDGE_LOW) && (dat_ext > thr_hi)) begin
          state   <= EDGE_HIGH;
          trg_pdg <= 1'b1;
        end else if ((state == EDGE_HIGH) && (dat_ext < thr_lo)) begin
          state   <= EDGE_LOW;
          trg_ndg <= 1'b1;
        end
      end
    end
  end

endmodule: scope_edge

/* design/scope_top.sv */
//////////////////////////////
// scope acquisition front end
// registers, decimator and edge trigger
//////////////////////////////
`timescale 1ns/1ps

module scope_top #(
  int unsigned DWI = 14,  // input data width
  int unsigned DWO = 14,  // output data width
  int unsigned DWC = 17,  // decimation counter width
  int unsigned DWS = 4    // shift amount width
)(
  input  logic                            clk,
  input  logic                            rstn,
  // stream input
  input  logic signed [DWI-1:0]           sti_dat,
  input  logic                            sti_vld,
  output logic                            sti_rdy,
  // stream output
  output logic signed [DWO-1:0]           sto_dat,
  output logic                            sto_vld,
  input  logic                            sto_rdy,
  // triggers, 0 rising, 1 falling
  output logic [1:0]                      trg_out,
  // system bus
  input  logic [scope_pkg::sys_aw_t-1:0]  sys_addr,
  input  logic [31:0]                     sys_wdata,
  input  logic                            sys_wen,
  input  logic                            sys_ren,
  output logic [31:0]                     sys_rdata,
  output logic                            sys_ack
);

  logic                  ctl_clr;
  logic                  cfg_avg;
  logic [DWC-1:0]        cfg_dec;
  logic [DWS-1:0]        cfg_shr;
  logic signed [DWO-1:0] cfg_lvl;  // compared with decimated data
  logic signed [DWO-1:0] cfg_hst;

  //////////////////////////////
  // register bank
  //////////////////////////////

  scope_regs #(
    .DWI (DWO),  // thresholds follow output width
    .DWC (DWC),
    .DWS (DWS)
  ) u_regs (
    .clk       (clk),
    .rstn      (rstn),
    .sys_addr  (sys_addr),
    .sys_wdata (sys_wdata),
    .sys_wen   (sys_wen),
    .sys_ren   (sys_ren),
    .sys_rdata (sys_rdata),
    .sys_ack   (sys_ack),
    .ctl_clr   (ctl_clr),
    .cfg_avg   (cfg_avg),
    .cfg_dec   (cfg_dec),
    .cfg_shr   (cfg_shr),
    .cfg_lvl   (cfg_lvl),
    .cfg_hst   (cfg_hst)
  );

  //////////////////////////////
  // decimation
  //////////////////////////////

  scope_dec_avg #(
    .DWI (DWI),
    .DWO (DWO),
    .DWC (DWC),
    .DWS (DWS)
  ) u_dec (
    .clk     (clk),
    .rstn    (rstn),
    .ctl_clr (ctl_clr),
    .cfg_avg (cfg_avg),
    .cfg_dec (cfg_dec),
    .cfg_shr (cfg_shr),
    .sti_dat (sti_dat),
    .sti_vld (sti_vld),
    .sti_rdy (sti_rdy),
    .sto_dat (sto_dat),
    .sto_vld (sto_vld),
    .sto_rdy (sto_rdy)
  );

  // edge detector only watches the output stream
  scope_edge #(
    .DWI (DWO)
  ) u_edge (
    .clk     (clk),
    .rstn    (rstn),
    .sti_dat (sto_dat),
    .sti_vld (sto_vld),
    .sti_rdy (sto_rdy),
    .cfg_lvl (cfg_lvl),
    .cfg_hst (cfg_hst),
    .trg_pdg (trg_out[0]),
    .trg_ndg (trg_out[1])
  );

endmodule: scope_top

/* tests/scope_clk_gen.sv */
//////////////////////////////
// testbench clock and reset
//////////////////////////////
`timescale 1ns/1ps

module scope_clk_gen #(
  int unsigned PERIOD_NS = 40,  // clock period
  int unsigned RST_CYC   = 8    // cycles held in reset
)(
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release just after an edge, like all other inputs
  initial begin
    rstn = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    #2 rstn = 1'b1;
  end

endmodule: scope_clk_gen

/* tests/scope_tb.sv */
//////////////////////////////
// scope front end testbench
// register, decimator and trigger tests
//////////////////////////////
`timescale 1ns/1ps

module scope_tb;

  import scope_pkg::*;

  localparam int unsigned DWI = 14;
  localparam int unsigned DWO = 14;
  localparam int unsigned DWC = 17;
  localparam int unsigned DWS = 4;
  localparam int TIMEOUT_CYC  = 20000;  // full list needs about 6000

  logic                  clk;
  logic                  rstn;
  logic signed [DWI-1:0] sti_dat;
  logic                  sti_vld;
  logic                  sti_rdy;
  logic signed [DWO-1:0] sto_dat;
  logic                  sto_vld;
  logic                  sto_rdy;
  logic [1:0]            trg_out;
  logic [31:0]           sys_addr;
  logic [31:0]           sys_wdata;
  logic                  sys_wen;
  logic                  sys_ren;
  logic [31:0]           sys_rdata;
  logic                  sys_ack;

  // monitor side
  logic [DWO-1:0] out_q [$];  // every output transfer
  int             pdg_q [$];  // transfer index of each rising pulse
  int             ndg_q [$];
  int             xfer_cnt = 0;
  logic           prev_trn = 1'b0;
  int             mon_err  = 0;

  // model side
  logic [DWO-1:0] exp_q [$];
  logic           cur_avg;
  int             cur_dec;
  int             cur_shr;
  longint         grp_sum;
  int             grp_cnt;

  logic [15:0] lfsr = 16'd47;  // seed
  int          cyc  = 0;
  int          err_cnt = 0;
  int          test_err0;
  int          n_ok  = 0;
  int          n_bad = 0;
  string       cur_test;

  scope_clk_gen #(.PERIOD_NS(40), .RST_CYC(8)) u_clk (.clk(clk), .rstn(rstn));

  scope_top #(
    .DWI (DWI),
    .DWO (DWO),
    .DWC (DWC),
    .DWS (DWS)
  ) u_dut (
    .clk       (clk),
    .rstn      (rstn),
    .sti_dat   (sti_dat),
    .sti_vld   (sti_vld),
    .sti_rdy   (sti_rdy),
    .sto_dat   (sto_dat),
    .sto_vld   (sto_vld),
    .sto_rdy   (sto_rdy),
    .trg_out   (trg_out),
    .sys_addr  (sys_addr),
    .sys_wdata (sys_wdata),
    .sys_wen   (sys_wen),
    .sys_ren   (sys_ren),
    .sys_rdata (sys_rdata),
    .sys_ack   (sys_ack)
  );

  //////////////////////////////
  // monitor and timeout
  //////////////////////////////

  // mid cycle sampling, all signals settled
  always @(negedge clk) begin
    if (rstn) begin
      if (trg_out[0]) begin
        if (!prev_trn) begin
          $display("rising trigger pulse without an output transfer one cycle before");
          mon_err++;
        end
        pdg_q.push_back(xfer_cnt - 1);  // belongs to last transfer
      end
      if (trg_out[1]) begin
        if (!prev_trn) begin
          $display("falling trigger pulse without an output transfer one cycle before");
          mon_err++;
        end
        ndg_q.push_back(xfer_cnt - 1);
      end
      prev_trn = sto_vld && sto_rdy;  // completes at next edge
      if (prev_trn) begin
        out_q.push_back(sto_dat);
        xfer_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("timeout, the run was stopped after %0d cycles", cyc);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // fibonacci lfsr x^16+x^14+x^13+x^11, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // readback rule: masked to field width, lvl and hst sign extended
  function automatic logic [31:0] reg_expect(input reg_addr_e a, input logic [31:0] w);
    case (a)
      REG_AVG: return {31'd0, w[0]};
      REG_DEC: return w & ((32'd1 << DWC) - 32'd1);
      REG_SHR: return w & ((32'd1 << DWS) - 32'd1);
      REG_LVL, REG_HST: return {{(32-DWO){w[DWO-1]}}, w[DWO-1:0]};
      default: return 32'd0;
    endcase
  endfunction

  task check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task bus_write(input logic [31:0] addr, input logic [31:0] data);
    int lat;
    sys_addr  = addr;
    sys_wdata = data;
    sys_wen   = 1'b1;
    @(negedge clk);
    check("ack before write edge", 32'd0, 32'(sys_ack));  // no early or stuck ack
    @(posedge clk);
    #2;
    sys_wen = 1'b0;
    lat = 1;
    @(negedge clk);
    while (!sys_ack && lat < 8) begin  // give up after a few cycles
      @(negedge clk);
      lat++;
    end
    if (!sys_ack) begin
      $display("%s: bus write to %h was never acknowledged", cur_test, addr);
      err_cnt++;
    end else begin
      check("write ack latency", 32'd1, 32'(lat));
    end
    @(posedge clk);
    #2;
  endtask

  task bus_read(input logic [31:0] addr, output logic [31:0] data);
    int lat;
    sys_addr = addr;
    sys_ren  = 1'b1;
    @(negedge clk);
    check("ack before read edge", 32'd0, 32'(sys_ack));
    @(posedge clk);
    #2;
    sys_ren = 1'b0;
    lat = 1;
    @(negedge clk);
    while (!sys_ack && lat < 8) begin
      @(negedge clk);
      lat++;
    end
    data = sys_rdata;  // valid with ack
    if (!sys_ack) begin
      $display("%s: bus read from %h was never acknowledged", cur_test, addr);
      err_cnt++;
    end else begin
      check("read ack latency", 32'd1, 32'(lat));
    end
    @(posedge clk);
    #2;
  endtask

  // decimator reference, straight from the group rule
  task model_push(input logic signed [DWI-1:0] d);
    longint res;
    grp_sum = grp_sum + longint'(d);
    grp_cnt++;
    if (grp_cnt >= ((cur_dec == 0) ? 1 : cur_dec)) begin
      res = cur_avg ? grp_sum : longint'(d);  // sum or last of group
      res = res >>> cur_shr;
      exp_q.push_back(res[DWO-1:0]);
      grp_sum = 0;
      grp_cnt = 0;
    end
  endtask

  task model_clear();
    grp_sum = 0;
    grp_cnt = 0;
  endtask

  // holds valid until ready seen mid cycle
  task send_sample(input logic signed [DWI-1:0] d);
    logic taken;
    int   n_exp;
    sti_dat = d;
    sti_vld = 1'b1;
    taken   = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = sti_rdy;
      @(posedge clk);
      #2;
    end
    sti_vld = 1'b0;
    n_exp = exp_q.size();
    model_push(d);
    // valid follows the closing sample by one cycle
    check("output valid after input", 32'(exp_q.size() != n_exp), 32'(sto_vld));
  endtask

  task send_random(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = rand_bits(DWI);
      send_sample(r[DWI-1:0]);
    end
  endtask

  task set_config(input logic avg, input int dec, input int shr);
    bus_write(32'(REG_AVG), 32'(avg));
    bus_write(32'(REG_DEC), 32'(dec));
    bus_write(32'(REG_SHR), 32'(shr));
    bus_write(32'(REG_CTL), 32'd1);  // start from an empty group
    cur_avg = avg;
    cur_dec = dec;
    cur_shr = shr;
    model_clear();
  endtask

  task wait_outputs(input int n);
    int waited;
    waited = 0;
    while (out_q.size() < n && waited < 1000) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (out_q.size() < n) begin
      $display("%s: only %0d of %0d outputs arrived", cur_test, out_q.size(), n);
      err_cnt++;
    end
  endtask

  task compare_outputs(input int first);
    wait_outputs(exp_q.size());
    idle(4);  // catch duplicates
    check("output count", 32'(exp_q.size()), 32'(out_q.size()));
    for (int i = first; i < exp_q.size() && i < out_q.size(); i++) begin
      check("output value", 32'(exp_q[i]), 32'(out_q[i]));
    end
  endtask

  task begin_test(input string name);
    cur_test  = name;
    test_err0 = err_cnt + mon_err;
  endtask

  task end_test();
    int n;
    n = err_cnt + mon_err - test_err0;
    if (n == 0) begin
      n_ok++;
      $display("test %s: ok", cur_test);
    end else begin
      n_bad++;
      $display("test %s: FAIL with %0d errors", cur_test, n);
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task reset_values();
    begin_test("reset_values");
    @(negedge clk);  // reset applied by now
    check("sti_rdy in reset", 32'd0, 32'(sti_rdy));
    check("sto_vld in reset", 32'd0, 32'(sto_vld));
    check("trg_out in reset", 32'd0, 32'(trg_out));
    check("sys_ack in reset", 32'd0, 32'(sys_ack));
    wait (rstn === 1'b1);
    @(posedge clk);
    #2;
    check("sti_rdy after reset", 32'd1, 32'(sti_rdy));  // first cycle out of reset
    end_test();
  endtask

  task reg_access();
    reg_addr_e   sel;
    logic [31:0] wv [5];
    logic [31:0] rv;
    begin_test("reg_access");
    for (int r = 0; r < 2; r++) begin  // all ones, then random
      for (int i = 0; i < 5; i++) begin
        wv[i] = (r == 0) ? 32'hffff_ffff : rand_bits(32);
        bus_write(32'h8 + 32'(4 * i), wv[i]);  // avg .. hst are contiguous
      end
      for (int i = 0; i < 5; i++) begin
        sel = reg_addr_e'(20'h8 + 20'(4 * i));
        bus_read(32'(sel), rv);
        check("readback", reg_expect(sel, wv[i]), rv);
      end
    end
    bus_read(32'(REG_CTL), rv);
    check("ctl read", 32'd0, rv);
    bus_read(32'h0000_0004, rv);
    check("unmapped read", 32'd0, rv);
    bus_read(32'h000f_fffc, rv);
    check("unmapped read", 32'd0, rv);
    bus_read(32'hab00_000c, rv);  // only bits 19:0 decoded
    check("aliased read", reg_expect(REG_DEC, wv[1]), rv);
    end_test();
  endtask

  task pass_through();
    int first;
    begin_test("pass_through");
    set_config(1'b0, 1, 0);
    first = exp_q.size();
    send_random(64);
    compare_outputs(first);
    end_test();
  endtask

  task decimate_plain();
    int first;
    begin_test("decimate_plain");
    set_config(1'b0, 5, 0);
    first = exp_q.size();
    send_random(50);
    compare_outputs(first);
    end_test();
  endtask

  task average_clear();
    int first;
    begin_test("average_clear");
    set_config(1'b1, 8, 3);
    first = exp_q.size();
    send_random(32);
    send_random(5);  // partial group
    bus_write(32'(REG_CTL), 32'd1);
    model_clear();
    send_random(8);
    compare_outputs(first);
    end_test();
  endtask

  task back_pressure();
    int             first;
    logic [31:0]    r;
    logic [31:0]    rb;
    logic [DWI-1:0] dat [60];
    logic           bp_done;
    begin_test("back_pressure");
    set_config(1'b1, 3, 2);
    first = exp_q.size();
    for (int i = 0; i < 60; i++) begin  // data drawn before the fork
      r      = rand_bits(DWI);
      dat[i] = r[DWI-1:0];
    end
    bp_done = 1'b0;
    fork
      begin
        for (int i = 0; i < 60; i++) begin
          send_sample(dat[i]);
        end
        bp_done = 1'b1;
      end
      begin
        while (!bp_done) begin
          rb      = rand_bits(1);
          sto_rdy = rb[0];  // random stall
          @(posedge clk);
          #2;
        end
      end
    join
    sto_rdy = 1'b1;
    compare_outputs(first);
    end_test();
  endtask

  task edge_trigger();
    int                    first;
    int                    pbase;
    int                    nbase;
    int                    v;
    int                    lvl;
    int                    hst;
    int                    ramp  [$];
    int                    exp_p [$];
    int                    exp_n [$];
    edge_state_e           st;
    logic signed [DWO-1:0] s;
    begin_test("edge_trigger");
    lvl = 100;
    hst = 20;  // band 80 .. 120
    set_config(1'b0, 1, 0);
    bus_write(32'(REG_LVL), 32'(lvl));
    bus_write(32'(REG_HST), 32'(hst));
    send_sample(-14'sd4000);  // forces low state
    wait_outputs(exp_q.size());
    idle(2);
    first = exp_q.size();
    pbase = pdg_q.size();
    nbase = ndg_q.size();
    for (v = -200; v <= 300; v += 20) ramp.push_back(v);
    for (v = 300; v >= -300; v -= 20) ramp.push_back(v);
    for (v = -300; v <= 110; v += 10) ramp.push_back(v);  // stops inside band
    for (v = 110; v >= 90; v -= 5) ramp.push_back(v);
    for (v = 90; v <= 200; v += 10) ramp.push_back(v);
    foreach (ramp[i]) begin
      send_sample(ramp[i][DWI-1:0]);
    end
    compare_outputs(first);
    idle(2);
    // schmitt model over the expected outputs
    st = EDGE_LOW;
    for (int i = first; i < exp_q.size(); i++) begin
      s = exp_q[i];
      v = int'(s);
      if ((st == EDGE_LOW) && (v > lvl + hst)) begin
        st = EDGE_HIGH;
        exp_p.push_back(i);
      end else if ((st == EDGE_HIGH) && (v < lvl - hst)) begin
        st = EDGE_LOW;
        exp_n.push_back(i);
      end
    end
    check("rising count", 32'(exp_p.size()), 32'(pdg_q.size() - pbase));
    check("falling count", 32'(exp_n.size()), 32'(ndg_q.size() - nbase));
    for (int i = 0; i < exp_p.size() && pbase + i < pdg_q.size(); i++) begin
      check("rising index", 32'(exp_p[i]), 32'(pdg_q[pbase + i]));
    end
    for (int i = 0; i < exp_n.size() && nbase + i < ndg_q.size(); i++) begin
      check("falling index", 32'(exp_n[i]), 32'(ndg_q[nbase + i]));
    end
    end_test();
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    sti_dat   = '0;
    sti_vld   = 1'b0;
    sto_rdy   = 1'b1;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    cur_avg   = 1'b0;
    cur_dec   = 0;
    cur_shr   = 0;
    grp_sum   = 0;
    grp_cnt   = 0;
    reset_values();
    reg_access();
    pass_through();
    decimate_plain();
    average_clear();
    back_pressure();
    edge_trigger();
    $display("summary: %0d tests ok, %0d tests with errors", n_ok, n_bad);
    if ((n_bad == 0) && (err_cnt + mon_err == 0)) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule: scope_tb

/* src.f */
design/scope_pkg.sv
design/scope_regs.sv
design/scope_dec_avg.sv
design/scope_edge.sv
design/scope_top.sv
tests/scope_clk_gen.sv
tests/scope_tb.sv

/* Makefile */
# verilator build and run of the scope front end testbench

obj_dir/Vscope_tb: src.f design/scope_pkg.sv design/scope_regs.sv design/scope_dec_avg.sv \
		design/scope_edge.sv design/scope_top.sv tests/scope_clk_gen.sv tests/scope_tb.sv
	verilator --binary --timing --timescale 1ns/1ps --top-module scope_tb \
		-f src.f -o Vscope_tb

run: obj_dir/Vscope_tb
	./obj_dir/Vscope_tb | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
